/* hw/addr_gen.sv */
module addr_gen (
  input  logic [7:0]                  modrm,
  input  logic [7:0]                  sib,
  input  logic [opnd_pkg::word_w-1:0] disp,
  input  logic                        has_sib,
  input  opnd_pkg::cmd_e              cmd,
  input  logic [opnd_pkg::word_w-1:0] eax,
  input  logic [opnd_pkg::word_w-1:0] ecx,
  input  logic [opnd_pkg::word_w-1:0] edx,
  input  logic [opnd_pkg::word_w-1:0] ebx,
  input  logic [opnd_pkg::word_w-1:0] esp,
  input  logic [opnd_pkg::word_w-1:0] ebp,
  input  logic [opnd_pkg::word_w-1:0] esi,
  input  logic [opnd_pkg::word_w-1:0] edi,
  input  logic                        hint1_is_write,
  input  logic [opnd_pkg::word_w-1:0] hint1_address,
  input  logic [opnd_pkg::word_w-1:0] hint1_data,
  input  logic                        hint2_is_write,
  input  logic [opnd_pkg::word_w-1:0] hint2_address,
  input  logic [opnd_pkg::word_w-1:0] hint2_data,
  output logic [opnd_pkg::word_w-1:0] mem_addr,
  output logic [opnd_pkg::word_w-1:0] mem_val
);

  logic [opnd_pkg::word_w-1:0] reg_file [8];
  logic [2:0]                  base_sel;
  logic [2:0]                  index_sel;
  logic                        no_base;
  logic                        no_index;
  logic [opnd_pkg::word_w-1:0] base_val;
  logic [opnd_pkg::word_w-1:0] index_val;
  logic                        hint1_hit;
  logic                        hint2_hit;

  assign reg_file[0] = eax;
  assign reg_file[1] = ecx;
  assign reg_file[2] = edx;
  assign reg_file[3] = ebx;
  assign reg_file[4] = esp;
  assign reg_file[5] = ebp;
  assign reg_file[6] = esi;
  assign reg_file[7] = edi;

  // With SIB the base comes from SIB, otherwise from ModR/M rm
  assign base_sel  = has_sib ? sib[2:0] : modrm[2:0];
  assign index_sel = sib[5:3];

  // Encoding 5 in mod 0 drops the base in favour of a bare disp32
  assign no_base  = modrm[7:6] == 2'b00 && base_sel == 3'd5;
  // Index 4 is the "no index" escape, since ESP cannot be scaled
  assign no_index = !has_sib || index_sel == 3'd4;

  assign base_val  = no_base ? '0 : reg_file[base_sel];
  assign index_val = no_index ? '0 : reg_file[index_sel];

  // Scale is a left shift of the index by SIB bits 7..6
  assign mem_addr = base_val + (index_val << sib[7:6]) + disp;

  // Only read hints can supply data for a source operand
  assign hint1_hit = !hint1_is_write && hint1_address == mem_addr;
  assign hint2_hit = !hint2_is_write && hint2_address == mem_addr;

  // LEA takes the address itself and never touches memory
  always_comb begin
    if (cmd == opnd_pkg::cmd_lea) begin
      mem_val = mem_addr;
    end else if (hint1_hit) begin
      mem_val = hint1_data;
    end else if (hint2_hit) begin
      mem_val = hint2_data;
    end else begin
      mem_val = '0;
    end
  end

endmodule

/* hw/modrm_parser.sv */
module modrm_parser (
  input  logic [opnd_pkg::instr_w-1:0] instr,
  input  opnd_pkg::opnd_form_e         opnd_form,
  input  logic                         imm_1byte,
  output logic [7:0]                   modrm,
  output logic [7:0]                   sib,
  output logic [opnd_pkg::word_w-1:0]  disp,
  output logic [opnd_pkg::word_w-1:0]  imm,
  output logic                         has_modrm,
  output logic                         has_sib,
  output logic                         rm_is_direct,
  output logic [opnd_pkg::len_w-1:0]   body_len
);

  logic [1:0]                   mod_field;
  logic [2:0]                   rm_field;
  logic                         has_imm;
  logic                         is_disp8;
  logic                         is_disp32;
  logic [opnd_pkg::len_w-1:0]   disp_len;
  logic [opnd_pkg::len_w-1:0]   imm_len;
  logic [opnd_pkg::len_w-1:0]   disp_off;
  logic [opnd_pkg::len_w-1:0]   imm_off;
  logic [opnd_pkg::instr_w-1:0] disp_bytes;
  logic [opnd_pkg::instr_w-1:0] imm_bytes;

  // Byte 0 is the opcode, so ModR/M sits in byte 1 and SIB in byte 2
  assign has_modrm = opnd_form inside {opnd_pkg::form_rm_reg, opnd_pkg::form_reg_rm,
                                       opnd_pkg::form_rm_imm};
  assign has_imm   = opnd_form inside {opnd_pkg::form_reg_imm, opnd_pkg::form_eax_imm,
                                       opnd_pkg::form_rm_imm, opnd_pkg::form_imm};

  assign modrm     = has_modrm ? instr[15:8] : 8'h00;
  assign mod_field = modrm[7:6];
  assign rm_field  = modrm[2:0];

  // mod 3 names a register directly and never carries SIB or displacement
  assign rm_is_direct = has_modrm && mod_field == 2'b11;

  // rm 4 escapes to a SIB byte in every memory mode
  assign has_sib = has_modrm && mod_field != 2'b11 && rm_field == 3'd4;
  assign sib     = has_sib ? instr[23:16] : 8'h00;

  // mod 0 with rm 5, or with SIB base 5, means disp32 and no base register
  assign is_disp8  = has_modrm && mod_field == 2'b01;
  assign is_disp32 = has_modrm && (mod_field == 2'b10 ||
                     (mod_field == 2'b00 && !has_sib && rm_field == 3'd5) ||
                     (mod_field == 2'b00 && has_sib && sib[2:0] == 3'd5));

  always_comb begin
    if (is_disp32) begin
      disp_len = 4'd4;
    end else if (is_disp8) begin
      disp_len = 4'd1;
    end else begin
      disp_len = 4'd0;
    end
  end

  // Displacement follows SIB when there is one, else directly follows ModR/M
  assign disp_off   = 4'd2 + 4'(has_sib);
  assign disp_bytes = instr >> {disp_off, 3'b000};

  always_comb begin
    if (is_disp32) begin
      disp = disp_bytes[31:0];
    end else if (is_disp8) begin
      disp = {{24{disp_bytes[7]}}, disp_bytes[7:0]};
    end else begin
      disp = '0;
    end
  end

  // The immediate comes last, after whatever addressing bytes are present
  assign imm_off   = 4'd1 + 4'(has_modrm) + 4'(has_sib) + disp_len;
  assign imm_bytes = instr >> {imm_off, 3'b000};

  always_comb begin
    if (!has_imm) begin
      imm     = '0;
      imm_len = 4'd0;
    end else if (imm_1byte) begin
      imm     = {{24{imm_bytes[7]}}, imm_bytes[7:0]};
      imm_len = 4'd1;
    end else begin
      imm     = imm_bytes[31:0];
      imm_len = 4'd4;
    end
  end

  assign body_len = 4'(has_modrm) + 4'(has_sib) + disp_len + imm_len;

endmodule

/* hw/opnd_decode.sv */
module opnd_decode (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         in_valid,
  input  logic [opnd_pkg::instr_w-1:0] instr,
  input  opnd_pkg::opnd_form_e         opnd_form,
  input  opnd_pkg::cmd_e               cmd,
  input  logic                         imm_1byte,
  input  logic                         opnd0_is_read,
  input  logic                         opnd0_is_write,
  input  logic                         opnd1_is_read,
  input  logic                         opnd1_is_write,
  input  logic [opnd_pkg::word_w-1:0]  eax,
  input  logic [opnd_pkg::word_w-1:0]  ecx,
  input  logic [opnd_pkg::word_w-1:0]  edx,
  input  logic [opnd_pkg::word_w-1:0]  ebx,
  input  logic [opnd_pkg::word_w-1:0]  esp,
  input  logic [opnd_pkg::word_w-1:0]  ebp,
  input  logic [opnd_pkg::word_w-1:0]  esi,
  input  logic [opnd_pkg::word_w-1:0]  edi,
  input  logic                         hint1_is_write,
  input  logic [opnd_pkg::word_w-1:0]  hint1_address,
  input  logic [opnd_pkg::word_w-1:0]  hint1_data,
  input  logic                         hint2_is_write,
  input  logic [opnd_pkg::word_w-1:0]  hint2_address,
  input  logic [opnd_pkg::word_w-1:0]  hint2_data,
  output logic                         out_valid,
  output logic [opnd_pkg::len_w-1:0]   instr_body_len,
  output logic [opnd_pkg::word_w-1:0]  opnd0,
  output logic [opnd_pkg::word_w-1:0]  opnd1,
  output opnd_pkg::dest_kind_e         dest0_kind,
  output opnd_pkg::dest_kind_e         dest1_kind,
  output logic [opnd_pkg::word_w-1:0]  dest0_sel,
  output logic [opnd_pkg::word_w-1:0]  dest1_sel
);

  logic [7:0]                  modrm;
  logic [7:0]                  sib;
  logic [opnd_pkg::word_w-1:0] disp;
  logic [opnd_pkg::word_w-1:0] imm;
  logic                        has_modrm;
  logic                        has_sib;
  logic                        rm_is_direct;
  logic [opnd_pkg::len_w-1:0]  body_len;
  opnd_pkg::reg_e              opnd0_regsel;
  opnd_pkg::reg_e              opnd1_regsel;
  logic [opnd_pkg::word_w-1:0] opnd0_regval;
  logic [opnd_pkg::word_w-1:0] opnd1_regval;
  logic [opnd_pkg::word_w-1:0] mem_addr;
  logic [opnd_pkg::word_w-1:0] mem_val;
  logic                        opnd0_is_rm;
  logic                        opnd1_is_rm;
  logic                        opnd0_is_reg;
  logic                        opnd1_is_reg;
  logic                        opnd0_is_mem;
  logic                        opnd1_is_mem;
  logic                        opnd0_is_imm;
  logic                        opnd1_is_imm;
  opnd_pkg::dest_kind_e        nx_dest0_kind;
  opnd_pkg::dest_kind_e        nx_dest1_kind;

  // Read value of one operand, whatever its source turns out to be
  function automatic logic [opnd_pkg::word_w-1:0] read_value(
    input logic                        is_reg,
    input logic                        is_mem,
    input logic                        is_imm,
    input logic                        is_read,
    input logic [opnd_pkg::word_w-1:0] regval
  );
    if (is_imm) begin
      return imm;
    end else if (is_reg && is_read) begin
      return regval;
    end else if (is_mem && is_read) begin
      return mem_val;
    end
    return '0;
  endfunction

  // Immediates are never written, so they fall through to dest_none
  function automatic opnd_pkg::dest_kind_e dest_kind(
    input logic is_reg,
    input logic is_mem,
    input logic is_write
  );
    if (is_write && is_reg) begin
      return opnd_pkg::dest_reg;
    end else if (is_write && is_mem) begin
      return opnd_pkg::dest_mem;
    end
    return opnd_pkg::dest_none;
  endfunction

  // Registers are selected one-hot, memory by its effective address
  function automatic logic [opnd_pkg::word_w-1:0] dest_select(
    input opnd_pkg::dest_kind_e kind,
    input opnd_pkg::reg_e       regsel
  );
    case (kind)
      opnd_pkg::dest_reg: return opnd_pkg::word_w'(1) << regsel;
      opnd_pkg::dest_mem: return mem_addr;
      default:            return '0;
    endcase
  endfunction

  modrm_parser u_modrm_parser (
    .instr        (instr),
    .opnd_form    (opnd_form),
    .imm_1byte    (imm_1byte),
    .modrm        (modrm),
    .sib          (sib),
    .disp         (disp),
    .imm          (imm),
    .has_modrm    (has_modrm),
    .has_sib      (has_sib),
    .rm_is_direct (rm_is_direct),
    .body_len     (body_len)
  );

  reg_operand_sel u_reg_operand_sel (
    .opnd_form    (opnd_form),
    .opcode_reg   (instr[2:0]),
    .modrm        (modrm),
    .eax          (eax),
    .ecx          (ecx),
    .edx          (edx),
    .ebx          (ebx),
    .esp          (esp),
    .ebp          (ebp),
    .esi          (esi),
    .edi          (edi),
    .opnd0_regsel (opnd0_regsel),
    .opnd1_regsel (opnd1_regsel),
    .opnd0_regval (opnd0_regval),
    .opnd1_regval (opnd1_regval)
  );

  // One address generator is enough since at most one operand is r/m
  addr_gen u_addr_gen (
    .modrm          (modrm),
    .sib            (sib),
    .disp           (disp),
    .has_sib        (has_sib),
    .cmd            (cmd),
    .eax            (eax),
    .ecx            (ecx),
    .edx            (edx),
    .ebx            (ebx),
    .esp            (esp),
    .ebp            (ebp),
    .esi            (esi),
    .edi            (edi),
    .hint1_is_write (hint1_is_write),
    .hint1_address  (hint1_address),
    .hint1_data     (hint1_data),
    .hint2_is_write (hint2_is_write),
    .hint2_address  (hint2_address),
    .hint2_data     (hint2_data),
    .mem_addr       (mem_addr),
    .mem_val        (mem_val)
  );

  // The r/m operand is operand 1 only in the reg, r/m form
  assign opnd0_is_rm = has_modrm && opnd_form != opnd_pkg::form_reg_rm;
  assign opnd1_is_rm = has_modrm && opnd_form == opnd_pkg::form_reg_rm;

  assign opnd0_is_mem = opnd0_is_rm && !rm_is_direct;
  assign opnd1_is_mem = opnd1_is_rm && !rm_is_direct;

  assign opnd0_is_reg = (opnd0_is_rm && rm_is_direct) ||
                        opnd_form inside {opnd_pkg::form_reg, opnd_pkg::form_reg_imm,
                                          opnd_pkg::form_eax_imm, opnd_pkg::form_reg_rm};
  assign opnd1_is_reg = (opnd1_is_rm && rm_is_direct) || opnd_form == opnd_pkg::form_rm_reg;

  assign opnd0_is_imm = opnd_form == opnd_pkg::form_imm;
  assign opnd1_is_imm = opnd_form inside {opnd_pkg::form_reg_imm, opnd_pkg::form_eax_imm,
                                          opnd_pkg::form_rm_imm};

  assign nx_dest0_kind = dest_kind(opnd0_is_reg, opnd0_is_mem, opnd0_is_write);
  assign nx_dest1_kind = dest_kind(opnd1_is_reg, opnd1_is_mem, opnd1_is_write);

  // Outputs load only on an accepted item and hold until the next one
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid      <= 1'b0;
      instr_body_len <= '0;
      opnd0          <= '0;
      opnd1          <= '0;
      dest0_kind     <= opnd_pkg::dest_none;
      dest1_kind     <= opnd_pkg::dest_none;
      dest0_sel      <= '0;
      dest1_sel      <= '0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin
        instr_body_len <= body_len;
        opnd0      <= read_value(opnd0_is_reg, opnd0_is_mem, opnd0_is_imm, opnd0_is_read,
                                 opnd0_regval);
        opnd1      <= read_value(opnd1_is_reg, opnd1_is_mem, opnd1_is_imm, opnd1_is_read,
                                 opnd1_regval);
        dest0_kind <= nx_dest0_kind;
        dest1_kind <= nx_dest1_kind;
        dest0_sel  <= dest_select(nx_dest0_kind, opnd0_regsel);
        dest1_sel  <= dest_select(nx_dest1_kind, opnd1_regsel);
      end
    end
  end

  // The shared address generator only works if one r/m operand ever writes memory
  assert property (@(posedge clk) disable iff (reset)
    !(dest0_kind == opnd_pkg::dest_mem && dest1_kind == opnd_pkg::dest_mem))
    else $error("opnd_decode: both destinations are memory");

endmodule

/* hw/opnd_pkg.sv */
package opnd_pkg;

  // Data and address width of the 32-bit subset
  localparam int word_w = 32;

  // Opcode byte plus the longest body: ModR/M, SIB, disp32 and imm32
  localparam int instr_w = 88;

  // Body length never exceeds 10 bytes
  localparam int len_w = 4;

  // General registers in the order the x86 encodings number them
  typedef enum logic [2:0] {
    reg_eax,
    reg_ecx,
    reg_edx,
    reg_ebx,
    reg_esp,
    reg_ebp,
    reg_esi,
    reg_edi
  } reg_e;

  // Operand encodings handed over by the opcode decoder
  // The first named operand is operand 0, the second is operand 1
  typedef enum logic [2:0] {
    form_none,
    form_reg,
    form_reg_imm,
    form_eax_imm,
    form_rm_reg,
    form_reg_rm,
    form_rm_imm,
    form_imm
  } opnd_form_e;

  // Commands, of which only LEA changes how operands are decoded
  typedef enum logic [2:0] {
    cmd_mov,
    cmd_add,
    cmd_sub,
    cmd_cmp,
    cmd_lea,
    cmd_other
  } cmd_e;

  // Where the result of an operand is written back
  typedef enum logic [1:0] {
    dest_none,
    dest_reg,
    dest_mem
  } dest_kind_e;

endpackage

/* hw/reg_operand_sel.sv */
module reg_operand_sel (
  input  opnd_pkg::opnd_form_e        opnd_form,
  input  logic [2:0]                  opcode_reg,
  input  logic [7:0]                  modrm,
  input  logic [opnd_pkg::word_w-1:0] eax,
  input  logic [opnd_pkg::word_w-1:0] ecx,
  input  logic [opnd_pkg::word_w-1:0] edx,
  input  logic [opnd_pkg::word_w-1:0] ebx,
  input  logic [opnd_pkg::word_w-1:0] esp,
  input  logic [opnd_pkg::word_w-1:0] ebp,
  input  logic [opnd_pkg::word_w-1:0] esi,
  input  logic [opnd_pkg::word_w-1:0] edi,
  output opnd_pkg::reg_e              opnd0_regsel,
  output opnd_pkg::reg_e              opnd1_regsel,
  output logic [opnd_pkg::word_w-1:0] opnd0_regval,
  output logic [opnd_pkg::word_w-1:0] opnd1_regval
);

  logic [opnd_pkg::word_w-1:0] reg_file [8];

  // Register set laid out by encoding number so a selector indexes it directly
  assign reg_file[0] = eax;
  assign reg_file[1] = ecx;
  assign reg_file[2] = edx;
  assign reg_file[3] = ebx;
  assign reg_file[4] = esp;
  assign reg_file[5] = ebp;
  assign reg_file[6] = esi;
  assign reg_file[7] = edi;

  // Operand 0 comes from the opcode, ModR/M or an implicit EAX
  // The rm choice only matters when the top level sees a direct r/m
  always_comb begin
    case (opnd_form)
      opnd_pkg::form_reg,
      opnd_pkg::form_reg_imm: opnd0_regsel = opnd_pkg::reg_e'(opcode_reg);
      opnd_pkg::form_rm_reg,
      opnd_pkg::form_rm_imm:  opnd0_regsel = opnd_pkg::reg_e'(modrm[2:0]);
      opnd_pkg::form_reg_rm:  opnd0_regsel = opnd_pkg::reg_e'(modrm[5:3]);
      default:                opnd0_regsel = opnd_pkg::reg_eax;
    endcase
  end

  // Operand 1 is a register only in the two ModR/M register forms
  always_comb begin
    case (opnd_form)
      opnd_pkg::form_rm_reg: opnd1_regsel = opnd_pkg::reg_e'(modrm[5:3]);
      opnd_pkg::form_reg_rm: opnd1_regsel = opnd_pkg::reg_e'(modrm[2:0]);
      default:               opnd1_regsel = opnd_pkg::reg_eax;
    endcase
  end

  assign opnd0_regval = reg_file[opnd0_regsel];
  assign opnd1_regval = reg_file[opnd1_regsel];

endmodule

/* project.f */
hw/opnd_pkg.sv
hw/modrm_parser.sv
hw/reg_operand_sel.sv
hw/addr_gen.sv
hw/opnd_decode.sv
verif/opnd_checks.sv
verif/opnd_decode_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module opnd_decode_tb -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vopnd_decode_tb 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if ! printf '%s\n' "$output" | grep -qx '>>> PASS'; then
  echo "Pass message not found in simulation output"
  exit 1
fi
exit 0

/* verif/opnd_checks.sv */
module opnd_checks (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         in_valid,
  input  logic [opnd_pkg::instr_w-1:0] instr,
  input  opnd_pkg::opnd_form_e         opnd_form,
  input  opnd_pkg::cmd_e               cmd,
  input  logic                         imm_1byte,
  input  logic                         opnd0_is_read,
  input  logic                         opnd0_is_write,
  input  logic                         opnd1_is_read,
  input  logic                         opnd1_is_write,
  input  logic [opnd_pkg::word_w-1:0]  eax, ecx, edx, ebx, esp, ebp, esi, edi,
  input  logic                         hint1_is_write,
  input  logic [opnd_pkg::word_w-1:0]  hint1_address,
  input  logic [opnd_pkg::word_w-1:0]  hint1_data,
  input  logic                         hint2_is_write,
  input  logic [opnd_pkg::word_w-1:0]  hint2_address,
  input  logic [opnd_pkg::word_w-1:0]  hint2_data,
  input  logic                         out_valid,
  input  logic [opnd_pkg::len_w-1:0]   instr_body_len,
  input  logic [opnd_pkg::word_w-1:0]  opnd0,
  input  logic [opnd_pkg::word_w-1:0]  opnd1,
  input  opnd_pkg::dest_kind_e         dest0_kind,
  input  opnd_pkg::dest_kind_e         dest1_kind,
  input  logic [opnd_pkg::word_w-1:0]  dest0_sel,
  input  logic [opnd_pkg::word_w-1:0]  dest1_sel,
  output logic [opnd_pkg::word_w-1:0]  model_addr,
  output logic                         check_failed
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [opnd_pkg::len_w-1:0]  nx_len, exp_len;
  logic [opnd_pkg::word_w-1:0] nx_opnd0, nx_opnd1, nx_sel0, nx_sel1;
  logic [opnd_pkg::word_w-1:0] exp_opnd0, exp_opnd1, exp_sel0, exp_sel1;
  opnd_pkg::dest_kind_e        nx_kind0, nx_kind1, exp_kind0, exp_kind1;
  logic                        exp_valid;
  logic                        outputs_match;
  logic                        valid_fail = 1'b0;
  logic                        value_fail = 1'b0;

  // Little-endian field of up to four bytes that starts at byte number first
  function automatic logic [31:0] byte_field(input logic [opnd_pkg::instr_w-1:0] bytes,
                                             input int first, input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value[i*8 +: 8] = bytes[(first + i)*8 +: 8];
    end
    return value;
  endfunction

  // Immediates are always read and other sources only with their read flag
  function automatic logic [31:0] operand_value(input opnd_pkg::dest_kind_e src,
      input logic is_imm, input logic rd, input logic [31:0] regv, input logic [31:0] memv,
      input logic [31:0] immv);
    if (is_imm) return immv;
    if (!rd) return '0;
    if (src == opnd_pkg::dest_reg) return regv;
    if (src == opnd_pkg::dest_mem) return memv;
    return '0;
  endfunction

  function automatic logic [31:0] select_of(input opnd_pkg::dest_kind_e kind,
                                            input logic [2:0] regnum, input logic [31:0] addr);
    if (kind == opnd_pkg::dest_reg) return 32'd1 << regnum;
    if (kind == opnd_pkg::dest_mem) return addr;
    return '0;
  endfunction

  // Reference decode of the current inputs, straight from the encoding rules
  always_comb begin : model
    logic [31:0] regs [8];
    logic        has_rm, use_sib, direct, has_imm, imm0, imm1;
    logic [2:0]  base_reg, r0, r1;
    logic [7:0]  sib_byte;
    int          dlen, ilen, ipos;
    logic [31:0] disp, immv, base, index, mval;
    opnd_pkg::dest_kind_e rm_kind, src0, src1;
    regs = '{eax, ecx, edx, ebx, esp, ebp, esi, edi};
    has_rm = opnd_form inside {opnd_pkg::form_rm_reg, opnd_pkg::form_reg_rm,
                               opnd_pkg::form_rm_imm};
    has_imm = opnd_form inside {opnd_pkg::form_reg_imm, opnd_pkg::form_eax_imm,
                                opnd_pkg::form_rm_imm, opnd_pkg::form_imm};
    direct   = has_rm && instr[15:14] == 2'b11;
    use_sib  = has_rm && !direct && instr[10:8] == 3'd4;
    sib_byte = use_sib ? instr[23:16] : 8'h00;
    base_reg = use_sib ? sib_byte[2:0] : instr[10:8];
    // mod 1 is disp8, mod 2 disp32, mod 0 disp32 only for base encoding 5
    if (!has_rm || direct) dlen = 0;
    else if (instr[15:14] == 2'b01) dlen = 1;
    else if (instr[15:14] == 2'b10 || base_reg == 3'd5) dlen = 4;
    else dlen = 0;
    disp = byte_field(instr, 2 + int'(use_sib), dlen);
    if (dlen == 1) disp = {{24{disp[7]}}, disp[7:0]};
    ilen = !has_imm ? 0 : (imm_1byte ? 1 : 4);
    ipos = has_rm ? 2 + int'(use_sib) + dlen : 1;
    immv = byte_field(instr, ipos, ilen);
    if (ilen == 1) immv = {{24{immv[7]}}, immv[7:0]};
    nx_len = opnd_pkg::len_w'(int'(has_rm) + int'(use_sib) + dlen + ilen);
    base  = (instr[15:14] == 2'b00 && base_reg == 3'd5) ? '0 : regs[base_reg];
    index = (use_sib && sib_byte[5:3] != 3'd4) ? regs[sib_byte[5:3]] << sib_byte[7:6] : '0;
    model_addr = base + index + disp;
    if (cmd == opnd_pkg::cmd_lea) mval = model_addr;
    else if (!hint1_is_write && hint1_address == model_addr) mval = hint1_data;
    else if (!hint2_is_write && hint2_address == model_addr) mval = hint2_data;
    else mval = '0;
    // Operand sources by form, following the form table
    rm_kind = direct ? opnd_pkg::dest_reg : opnd_pkg::dest_mem;
    src0 = opnd_pkg::dest_none;
    src1 = opnd_pkg::dest_none;
    imm0 = 1'b0;
    imm1 = 1'b0;
    r0 = 3'd0;
    r1 = 3'd0;
    case (opnd_form)
      opnd_pkg::form_reg: begin
        src0 = opnd_pkg::dest_reg;
        r0   = instr[2:0];
      end
      opnd_pkg::form_reg_imm: begin
        src0 = opnd_pkg::dest_reg;
        r0   = instr[2:0];
        imm1 = 1'b1;
      end
      opnd_pkg::form_eax_imm: begin
        src0 = opnd_pkg::dest_reg;
        imm1 = 1'b1;
      end
      opnd_pkg::form_rm_reg: begin
        src0 = rm_kind;
        r0   = instr[10:8];
        src1 = opnd_pkg::dest_reg;
        r1   = instr[13:11];
      end
      opnd_pkg::form_reg_rm: begin
        src0 = opnd_pkg::dest_reg;
        r0   = instr[13:11];
        src1 = rm_kind;
        r1   = instr[10:8];
      end
      opnd_pkg::form_rm_imm: begin
        src0 = rm_kind;
        r0   = instr[10:8];
        imm1 = 1'b1;
      end
      opnd_pkg::form_imm: imm0 = 1'b1;
      default:            imm0 = 1'b0;
    endcase
    nx_opnd0 = operand_value(src0, imm0, opnd0_is_read, regs[r0], mval, immv);
    nx_opnd1 = operand_value(src1, imm1, opnd1_is_read, regs[r1], mval, immv);
    nx_kind0 = (opnd0_is_write && !imm0) ? src0 : opnd_pkg::dest_none;
    nx_kind1 = (opnd1_is_write && !imm1) ? src1 : opnd_pkg::dest_none;
    nx_sel0  = select_of(nx_kind0, r0, model_addr);
    nx_sel1  = select_of(nx_kind1, r1, model_addr);
  end

  // Expected outputs load on an accepted item and hold in between
  always @(posedge clk) begin
    if (reset) begin
      exp_valid <= 1'b0;
      exp_len   <= '0;
      exp_opnd0 <= '0;
      exp_opnd1 <= '0;
      exp_kind0 <= opnd_pkg::dest_none;
      exp_kind1 <= opnd_pkg::dest_none;
      exp_sel0  <= '0;
      exp_sel1  <= '0;
    end else begin
      exp_valid <= in_valid;
      if (in_valid) begin
        exp_len   <= nx_len;
        exp_opnd0 <= nx_opnd0;
        exp_opnd1 <= nx_opnd1;
        exp_kind0 <= nx_kind0;
        exp_kind1 <= nx_kind1;
        exp_sel0  <= nx_sel0;
        exp_sel1  <= nx_sel1;
      end
    end
  end

  task automatic show_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    if (got !== want) begin
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, want);
    end
  endtask

  // Every output is compared in every cycle, including the cycles between items
  assign outputs_match = instr_body_len == exp_len && opnd0 == exp_opnd0 &&
                         opnd1 == exp_opnd1 && dest0_kind == exp_kind0 &&
                         dest1_kind == exp_kind1 && dest0_sel == exp_sel0 &&
                         dest1_sel == exp_sel1;

  assert property (@(posedge clk) disable iff (reset) out_valid == exp_valid)
    else begin
      show_mismatch("out_valid", 32'($sampled(out_valid)), 32'($sampled(exp_valid)));
      valid_fail = 1'b1;
    end

  assert property (@(posedge clk) disable iff (reset) outputs_match)
    else begin
      show_mismatch("instr_body_len", 32'($sampled(instr_body_len)), 32'($sampled(exp_len)));
      show_mismatch("opnd0", $sampled(opnd0), $sampled(exp_opnd0));
      show_mismatch("opnd1", $sampled(opnd1), $sampled(exp_opnd1));
      show_mismatch("dest0_kind", 32'($sampled(dest0_kind)), 32'($sampled(exp_kind0)));
      show_mismatch("dest1_kind", 32'($sampled(dest1_kind)), 32'($sampled(exp_kind1)));
      show_mismatch("dest0_sel", $sampled(dest0_sel), $sampled(exp_sel0));
      show_mismatch("dest1_sel", $sampled(dest1_sel), $sampled(exp_sel1));
      value_fail = 1'b1;
    end

  assign check_failed = valid_fail | value_fail;

endmodule

/* verif/opnd_decode_tb.sv */
module opnd_decode_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int directed_items  = 8;
  localparam int random_items    = 400;
  localparam int watchdog_cycles = (directed_items + random_items) * 4 + 100;

  logic                         clk = 1'b0;
  logic                         reset;
  logic                         in_valid;
  logic [opnd_pkg::instr_w-1:0] instr;
  opnd_pkg::opnd_form_e         opnd_form;
  opnd_pkg::cmd_e               cmd;
  logic                         imm_1byte;
  logic                         opnd0_is_read, opnd0_is_write, opnd1_is_read, opnd1_is_write;
  logic [opnd_pkg::word_w-1:0]  eax, ecx, edx, ebx, esp, ebp, esi, edi;
  logic                         hint1_is_write, hint2_is_write;
  logic [opnd_pkg::word_w-1:0]  hint1_address, hint1_data, hint2_address, hint2_data;
  logic                         out_valid;
  logic [opnd_pkg::len_w-1:0]   instr_body_len;
  logic [opnd_pkg::word_w-1:0]  opnd0, opnd1, dest0_sel, dest1_sel;
  opnd_pkg::dest_kind_e         dest0_kind, dest1_kind;
  logic [opnd_pkg::word_w-1:0]  model_addr;
  logic                         check_failed;

  opnd_decode u_opnd_decode (.*);

  // Reference model and output assertions
  opnd_checks u_opnd_checks (.*);

  always #50 clk = ~clk;

  // Instruction bytes are given with byte 0, the opcode, in the low bits
  task automatic send_item(input opnd_pkg::opnd_form_e form, input opnd_pkg::cmd_e op,
                           input logic imm1, input logic [87:0] bytes, input logic [3:0] rw);
    in_valid  = 1'b1;
    opnd_form = form;
    cmd       = op;
    imm_1byte = imm1;
    instr     = bytes;
    {opnd0_is_read, opnd0_is_write, opnd1_is_read, opnd1_is_write} = rw;
    @(negedge clk);
  endtask

  task automatic set_hints(input logic w1, input logic [31:0] a1, input logic [31:0] d1,
                           input logic w2, input logic [31:0] a2, input logic [31:0] d2);
    hint1_is_write = w1;
    hint1_address  = a1;
    hint1_data     = d1;
    hint2_is_write = w2;
    hint2_address  = a2;
    hint2_data     = d2;
  endtask

  task automatic idle(input int cycles);
    in_valid = 1'b0;
    repeat (cycles) @(negedge clk);
  endtask

  task automatic random_item();
    int pick;
    in_valid  = 1'b1;
    instr     = {$urandom(), $urandom(), 24'($urandom())};
    opnd_form = opnd_pkg::opnd_form_e'(3'($urandom_range(7, 0)));
    cmd       = opnd_pkg::cmd_e'(3'($urandom_range(5, 0)));
    imm_1byte = 1'($urandom());
    {opnd0_is_read, opnd0_is_write, opnd1_is_read, opnd1_is_write} = 4'($urandom());
    eax = $urandom();
    ecx = $urandom();
    edx = $urandom();
    ebx = $urandom();
    esp = $urandom();
    ebp = $urandom();
    esi = $urandom();
    edi = $urandom();
    set_hints(1'($urandom()), $urandom(), $urandom(), 1'($urandom()), $urandom(), $urandom());
    // Let the model settle, then aim hints at its address so matches happen
    #1;
    pick = $urandom_range(3, 0);
    if (pick == 0 || pick == 2) hint1_address = model_addr;
    if (pick == 1 || pick == 2) hint2_address = model_addr;
    @(negedge clk);
  endtask

  initial begin
    wait (check_failed);
    $display(">>> FAIL");
    $fatal(1, "Output check failed");
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("Timeout: stimulus did not finish within %0d cycles", watchdog_cycles);
    $display(">>> FAIL");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    void'($urandom(32'hd9e7));
    reset = 1'b1;
    in_valid = 1'b0;
    instr = '0;
    opnd_form = opnd_pkg::form_none;
    cmd = opnd_pkg::cmd_mov;
    imm_1byte = 1'b0;
    {opnd0_is_read, opnd0_is_write, opnd1_is_read, opnd1_is_write} = 4'b0000;
    eax = 32'h0000_0100;
    ecx = 32'h0000_0011;
    edx = 32'h0000_0022;
    ebx = 32'h0000_1000;
    esp = 32'h0000_8000;
    ebp = 32'h0000_2000;
    esi = 32'h0000_0020;
    edi = 32'h0000_0044;
    set_hints(1'b0, '0, '0, 1'b0, '0, '0);
    repeat (5) @(negedge clk);
    reset = 1'b0;
    // Directed items run back to back through opcode register, EAX with imm8 and direct r/m
    send_item(opnd_pkg::form_reg, opnd_pkg::cmd_add, 1'b0, 88'h43, 4'b1100);
    send_item(opnd_pkg::form_eax_imm, opnd_pkg::cmd_add, 1'b1, 88'hF0_05, 4'b1100);
    send_item(opnd_pkg::form_rm_reg, opnd_pkg::cmd_mov, 1'b0, 88'hC8_01, 4'b1111);
    // [ebx - 0x80] through disp8 is served by hint 1
    set_hints(1'b0, 32'h0000_0F80, 32'hCAFE_0001, 1'b0, 32'h0000_0000, 32'h0000_0000);
    send_item(opnd_pkg::form_reg_rm, opnd_pkg::cmd_mov, 1'b0, 88'h80_53_8B, 4'b1110);
    // [ebx + esi*4] with imm32 skips the write hint 1 and is served by hint 2
    set_hints(1'b1, 32'h0000_1080, 32'hDEAD_0000, 1'b0, 32'h0000_1080, 32'hBEEF_0002);
    send_item(opnd_pkg::form_rm_imm, opnd_pkg::cmd_add, 1'b0, 88'h12345678_B3_04_81, 4'b1100);
    // LEA of a bare disp32
    send_item(opnd_pkg::form_reg_rm, opnd_pkg::cmd_lea, 1'b0, 88'h00C0FFEE_0D_8D, 4'b0110);
    // SIB with neither base nor index
    set_hints(1'b0, 32'h0000_0000, 32'h0000_0000, 1'b0, 32'h0000_4000, 32'h5EED_0003);
    send_item(opnd_pkg::form_rm_reg, opnd_pkg::cmd_sub, 1'b0, 88'h00004000_25_14_89, 4'b1110);
    // [ebp + disp32] hits hint 1 but all flags are clear
    set_hints(1'b0, 32'h0000_2010, 32'h1234_0004, 1'b0, 32'h0000_0000, 32'h0000_0000);
    send_item(opnd_pkg::form_rm_reg, opnd_pkg::cmd_cmp, 1'b0, 88'h00000010_BD_89, 4'b0000);
    idle(2);
    for (int i = 0; i < random_items; i++) begin
      random_item();
      idle(int'($urandom_range(2, 0)));
    end
    idle(3);
    if (check_failed) begin
      $display(">>> FAIL");
      $fatal(1, "Output check failed");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule
